/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tbSceneChange
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
source/sceneChangePkg.sv
source/sceneChangeRegs.sv
source/squarePosGen.sv
source/dotSquareGen.sv
source/pixelFifo.sv
source/sceneChange.sv
sim/tbClock.sv
sim/tbChecker.sv
sim/tbSceneChange.sv

/* sim/tbChecker.sv */
`default_nettype none

module tbChecker (
	input  wire logic                    iClk,
	input  wire logic                    arstN,
	input  wire logic                    regWe,
	input  wire sceneChangePkg::regAddrT regAddr,
	input  wire sceneChangePkg::colorT   regWdata,
	input  wire sceneChangePkg::hPosT    iHpos,
	input  wire sceneChangePkg::vPosT    iVpos,
	input  wire logic                    iFe,
	input  wire logic                    iEds,
	input  wire logic                    iEdd,
	input  wire logic                    oFull,
	input  wire logic                    oVdd,
	input  wire sceneChangePkg::colorT   oDd,
	input  wire logic                    oEmp,
	input  wire logic                    endOfTest,
	output int                           dataErrs,
	output int                           flagErrs,
	output int                           miscErrs
);

	// ------------------------------------------------------------------
	// model state
	// ------------------------------------------------------------------
	sceneChangePkg::colorT mColor;
	int                    hDisp;
	int                    vDisp;
	int                    gainX;
	int                    gainY;
	int                    halfW;        // box half sizes
	int                    halfH;
	sceneChangePkg::colorT expectQ [$];  // dots still owed by the DUT
	sceneChangePkg::colorT want;
	int                    fill;         // entries inside the fifo
	logic                  wrPending;    // iEds seen at the last edge
	logic                  vddExp;
	logic                  readOk;
	logic                  sawFull;
	logic                  finalDone;

	// expected dot for one raster position
	function automatic sceneChangePkg::colorT expectedDot(input int h, input int v);
		int cx;
		int cy;
		cx = hDisp / 2;
		cy = vDisp / 2;
		if (h >= cx - halfW && h < cx + halfW && v >= cy - halfH && v < cy + halfH)
			return mColor;
		return '0;   // outside is black
	endfunction

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			flagErrs++;
			$display("ERROR %s got %h expected %h", name, got, exp);
		end
	endtask

	// ------------------------------------------------------------------
	// compare, values seen here are the ones before the edge
	// ------------------------------------------------------------------
	always @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			mColor    = sceneChangePkg::COLOR_RST;
			hDisp     = 640;
			vDisp     = 480;
			gainX     = 8;
			gainY     = 8;
			halfW     = 0;
			halfH     = 0;
			fill      = 0;
			wrPending = 1'b0;
			vddExp    = 1'b0;
			sawFull   = 1'b0;
			finalDone = 1'b0;
			dataErrs  = 0;
			flagErrs  = 0;
			miscErrs  = 0;
			expectQ.delete();
		end
		else
		begin
			checkFlag("oEmp", oEmp, fill == 0);
			checkFlag("oFull", oFull, fill == sceneChangePkg::FIFO_DEPTH);
			checkFlag("oVdd", oVdd, vddExp);
			if (oFull)
				sawFull = 1'b1;
			if (oVdd && expectQ.size() == 0)
			begin
				miscErrs++;
				$display("read data came out with no dot left to expect");
			end
			else if (oVdd)
			begin
				want = expectQ.pop_front();
				if (oDd !== want)
				begin
					dataErrs++;
					$display("ERROR oDd got %h expected %h", oDd, want);
				end
			end
			// fifo count, a write lands one edge after iEds
			readOk    = iEdd && (fill > 0);
			fill      = fill + (wrPending ? 1 : 0) - (readOk ? 1 : 0);
			vddExp    = readOk;
			wrPending = iEds;
			if (iEds)   // dot uses the box from before this edge
				expectQ.push_back(expectedDot(int'(iHpos), int'(iVpos)));
			if (regWe)
			begin
				case (regAddr)
					sceneChangePkg::ADDR_COLOR: mColor = regWdata;
					sceneChangePkg::ADDR_HDISP: hDisp = int'(regWdata[11:0]);
					sceneChangePkg::ADDR_VDISP: vDisp = int'(regWdata[11:0]);
					sceneChangePkg::ADDR_GAINX: gainX = int'(regWdata[6:0]);
					sceneChangePkg::ADDR_GAINY: gainY = int'(regWdata[6:0]);
					sceneChangePkg::ADDR_CTRL:
					begin
						if (regWdata[0])   // restart, box back to nothing
						begin
							halfW = 0;
							halfH = 0;
						end
					end
					default: ;
				endcase
			end
			if (iFe)
			begin
				halfW = (halfW + gainX > hDisp / 2) ? hDisp / 2 : halfW + gainX;   // clamp
				halfH = (halfH + gainY > vDisp / 2) ? vDisp / 2 : halfH + gainY;
			end
			if (endOfTest && !finalDone)
			begin
				finalDone = 1'b1;
				if (expectQ.size() != 0)
				begin
					miscErrs++;
					$display("%0d dots were written but never read back", expectQ.size());
				end
				if (!sawFull)
				begin
					miscErrs++;
					$display("the FIFO never reported full");
				end
			end
		end
	end

endmodule

`default_nettype wire

/* sim/tbClock.sv */
`default_nettype none

module tbClock (
	output logic iClk,
	output logic arstN
);

	localparam int HALF_PERIOD  = 4;   // 8 unit period
	localparam int RESET_CYCLES = 4;

	initial
	begin
		iClk = 1'b0;
		forever #HALF_PERIOD iClk = ~iClk;
	end

	initial
	begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge iClk);
		@(negedge iClk);
		arstN = 1'b1;   // release away from the active edge
	end

endmodule

`default_nettype wire

/* sim/tbSceneChange.sv */
`default_nettype none

module tbSceneChange;

	localparam int NUM_FRAMES     = 8;
	localparam int PIX_PER_FRAME  = 300;
	// up to ~4 cycles a dot, doubled, plus setup and the fifo fill
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * PIX_PER_FRAME * 4 * 2 + 800;
	localparam int SEED           = 41;

	logic                    iClk;
	logic                    arstN;
	logic                    regWe;
	sceneChangePkg::regAddrT regAddr;
	sceneChangePkg::colorT   regWdata;
	sceneChangePkg::hPosT    iHpos;
	sceneChangePkg::vPosT    iVpos;
	logic                    iFe;
	logic                    iEds;
	logic                    iEdd;
	logic                    oFull;
	logic                    oVdd;
	sceneChangePkg::colorT   oDd;
	logic                    oEmp;
	logic                    endOfTest;
	logic                    lastEds;   // no back to back iEds
	int                      dataErrs;
	int                      flagErrs;
	int                      miscErrs;
	int                      cycles = 0;

	tbClock u_clock (.iClk(iClk), .arstN(arstN));

	sceneChange u_sceneChange (
		.iClk(iClk), .arstN(arstN),
		.regWe(regWe), .regAddr(regAddr), .regWdata(regWdata),
		.iHpos(iHpos), .iVpos(iVpos), .iFe(iFe), .iEds(iEds),
		.oFull(oFull), .oVdd(oVdd), .oDd(oDd), .oEmp(oEmp), .iEdd(iEdd)
	);

	tbChecker u_checker (
		.iClk(iClk), .arstN(arstN),
		.regWe(regWe), .regAddr(regAddr), .regWdata(regWdata),
		.iHpos(iHpos), .iVpos(iVpos), .iFe(iFe), .iEds(iEds), .iEdd(iEdd),
		.oFull(oFull), .oVdd(oVdd), .oDd(oDd), .oEmp(oEmp), .endOfTest(endOfTest),
		.dataErrs(dataErrs), .flagErrs(flagErrs), .miscErrs(miscErrs)
	);

	// ------------------------------------------------------------------
	// stimulus tasks, everything changes on the falling edge
	// ------------------------------------------------------------------
	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(negedge iClk);
			regWe   = 1'b0;
			iFe     = 1'b0;
			iEds    = 1'b0;
			iEdd    = 1'b0;
			lastEds = 1'b0;
		end
	endtask

	// gap after it lets the box settle before the next dot
	task automatic writeReg(input sceneChangePkg::regAddrT addr, input sceneChangePkg::colorT data);
		@(negedge iClk);
		regWe    = 1'b1;
		regAddr  = addr;
		regWdata = data;
		iEds     = 1'b0;
		iEdd     = 1'b0;
		idleCycles(4);
	endtask

	task automatic frameEnd();
		@(negedge iClk);
		iFe  = 1'b1;
		iEds = 1'b0;
		iEdd = 1'b0;
		idleCycles(4);
	endtask

	// random dots inside hMax x vMax, random reads alongside
	task automatic runFrame(input int nPix, input int hMax, input int vMax);
		int sent;
		sent = 0;
		while (sent < nPix)
		begin
			@(negedge iClk);
			iEdd = ($urandom_range(3, 0) < 2);
			iEds = !lastEds && !oFull;
			if (iEds)
			begin
				iHpos = sceneChangePkg::hPosT'($urandom_range(hMax - 1, 0));
				iVpos = sceneChangePkg::vPosT'($urandom_range(vMax - 1, 0));
				sent++;
			end
			lastEds = iEds;
		end
		idleCycles(3);
	endtask

	task automatic drainFifo();
		@(negedge iClk);
		while (!oEmp)
		begin
			iEdd = 1'b1;
			@(negedge iClk);
		end
		iEdd = 1'b0;
	endtask

	// fill to full without reads, then empty it
	task automatic fillThenDrain();
		drainFifo();
		@(negedge iClk);
		while (!oFull)
		begin
			iEds    = !lastEds;
			iHpos   = sceneChangePkg::hPosT'($urandom_range(79, 0));
			iVpos   = sceneChangePkg::vPosT'($urandom_range(59, 0));
			lastEds = iEds;
			@(negedge iClk);
		end
		iEds    = 1'b0;
		lastEds = 1'b0;
		drainFifo();
		idleCycles(3);
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial
	begin
		void'($urandom(SEED));
		regWe     = 1'b0;
		regAddr   = '0;
		regWdata  = '0;
		iHpos     = '0;
		iVpos     = '0;
		iFe       = 1'b0;
		iEds      = 1'b0;
		iEdd      = 1'b0;
		endOfTest = 1'b0;
		lastEds   = 1'b0;
		@(posedge arstN);
		idleCycles(2);
		writeReg(sceneChangePkg::ADDR_COLOR, 16'hF81F);
		writeReg(sceneChangePkg::ADDR_HDISP, 16'd64);
		writeReg(sceneChangePkg::ADDR_VDISP, 16'd48);
		writeReg(sceneChangePkg::ADDR_GAINX, 16'd8);
		writeReg(sceneChangePkg::ADDR_GAINY, 16'd6);
		runFrame(PIX_PER_FRAME, 80, 60);   // no frame end yet, all black
		// growth, both halves hit the centre on the 4th frame end
		repeat (4)
		begin
			frameEnd();
			runFrame(PIX_PER_FRAME, 80, 60);
		end
		frameEnd();
		runFrame(PIX_PER_FRAME, 64, 48);   // display area fully coloured
		writeReg(sceneChangePkg::ADDR_CTRL, 16'h0001);
		runFrame(PIX_PER_FRAME, 80, 60);
		writeReg(sceneChangePkg::ADDR_COLOR, 16'h07E0);
		writeReg(sceneChangePkg::ADDR_GAINX, 16'd20);
		writeReg(sceneChangePkg::ADDR_GAINY, 16'd15);
		frameEnd();
		runFrame(PIX_PER_FRAME, 80, 60);
		fillThenDrain();
		endOfTest = 1'b1;
		@(posedge iClk);
		@(negedge iClk);
		$display("checks done: %0d data errors, %0d flag errors, %0d other errors",
			dataErrs, flagErrs, miscErrs);
		if (dataErrs + flagErrs + miscErrs == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

	// hang guard
	always @(posedge iClk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* source/dotSquareGen.sv */
`default_nettype none

module dotSquareGen (
	input  wire logic                   iClk,
	input  wire logic                   arstN,
	input  wire sceneChangePkg::hPosT   iHpos,
	input  wire sceneChangePkg::vPosT   iVpos,
	input  wire sceneChangePkg::colorT  color,
	input  wire sceneChangePkg::hCoordT leftX,
	input  wire sceneChangePkg::hCoordT rightX,
	input  wire sceneChangePkg::vCoordT topY,
	input  wire sceneChangePkg::vCoordT underY,
	output sceneChangePkg::colorT       pixel
);

	sceneChangePkg::hCoordT hPos;   // position widened to signed
	sceneChangePkg::vCoordT vPos;
	logic                   insideH;
	logic                   insideV;

	// positions are unsigned, so the cast puts a zero on top
	assign hPos = sceneChangePkg::hCoordT'(iHpos);
	assign vPos = sceneChangePkg::vCoordT'(iVpos);

	// half open box, right and under edges excluded
	assign insideH = (hPos >= leftX) && (hPos < rightX);
	assign insideV = (vPos >= topY) && (vPos < underY);

	// ------------------------------------------------------------------
	// registered dot
	// ------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			pixel <= '0;
		else if (insideH && insideV)
			pixel <= color;
		else
			pixel <= '0;   // black outside
	end

endmodule

`default_nettype wire

/* source/pixelFifo.sv */
`default_nettype none

module pixelFifo (
	input  wire logic                  iClk,
	input  wire logic                  arstN,
	// write side
	input  wire sceneChangePkg::colorT wData,
	input  wire logic                  we,
	output logic                       full,
	// read side
	output sceneChangePkg::colorT      rData,
	output logic                       rValid,   // rData valid one cycle after re
	input  wire logic                  re,
	output logic                       empty
);

	sceneChangePkg::colorT              mem [sceneChangePkg::FIFO_DEPTH];
	logic [sceneChangePkg::FIFO_AW:0]   wPtr;     // msb is the wrap bit
	logic [sceneChangePkg::FIFO_AW:0]   rPtr;
	logic                               doWrite;
	logic                               doRead;

	// wrap bits tell full from empty when the indexes match
	assign empty = (wPtr == rPtr);
	assign full  = (wPtr[sceneChangePkg::FIFO_AW] != rPtr[sceneChangePkg::FIFO_AW])
		&& (wPtr[sceneChangePkg::FIFO_AW-1:0] == rPtr[sceneChangePkg::FIFO_AW-1:0]);

	assign doWrite = we && !full;
	assign doRead  = re && !empty;   // read on empty is dropped

	// ------------------------------------------------------------------
	// pointers and read valid
	// ------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wPtr   <= '0;
			rPtr   <= '0;
			rValid <= 1'b0;
		end
		else
		begin
			if (doWrite)
				wPtr <= wPtr + 1'b1;
			if (doRead)
				rPtr <= rPtr + 1'b1;
			rValid <= doRead;
		end
	end

	// storage
	always_ff @(posedge iClk)
	begin
		if (doWrite)
			mem[wPtr[sceneChangePkg::FIFO_AW-1:0]] <= wData;
	end

	// read data register holds between reads
	always_ff @(posedge iClk)
	begin
		if (doRead)
			rData <= mem[rPtr[sceneChangePkg::FIFO_AW-1:0]];
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	noWriteFull: assert property (@(posedge iClk) disable iff (!arstN)
		we |-> !full)
		else $error("pixelFifo: write while full");

endmodule

`default_nettype wire

/* source/sceneChange.sv */
`default_nettype none

module sceneChange (
	input  wire logic                    iClk,
	input  wire logic                    arstN,
	// config writes
	input  wire logic                    regWe,
	input  wire sceneChangePkg::regAddrT regAddr,
	input  wire sceneChangePkg::colorT   regWdata,
	// raster from upstream
	input  wire sceneChangePkg::hPosT    iHpos,
	input  wire sceneChangePkg::vPosT    iVpos,
	input  wire logic                    iFe,     // frame end
	input  wire logic                    iEds,    // position valid this cycle
	// dot output
	output logic                         oFull,
	output logic                         oVdd,
	output sceneChangePkg::colorT        oDd,
	output logic                         oEmp,
	input  wire logic                    iEdd     // read request
);

	sceneChangePkg::colorT  color;
	sceneChangePkg::hCoordT hDisplay;
	sceneChangePkg::vCoordT vDisplay;
	sceneChangePkg::gainT   gainX;
	sceneChangePkg::gainT   gainY;
	logic                   restart;
	sceneChangePkg::hCoordT leftX;
	sceneChangePkg::hCoordT rightX;
	sceneChangePkg::vCoordT topY;
	sceneChangePkg::vCoordT underY;
	sceneChangePkg::colorT  pixel;     // one cycle behind iHpos/iVpos
	logic                   rWe;       // iEds lined up with pixel

	// ------------------------------------------------------------------
	// config and rectangle
	// ------------------------------------------------------------------
	sceneChangeRegs u_regs (
		.iClk(iClk), .arstN(arstN),
		.regWe(regWe), .regAddr(regAddr), .regWdata(regWdata),
		.color(color), .hDisplay(hDisplay), .vDisplay(vDisplay),
		.gainX(gainX), .gainY(gainY), .restart(restart)
	);

	squarePosGen u_posGen (
		.iClk(iClk), .arstN(arstN),
		.hDisplay(hDisplay), .vDisplay(vDisplay),
		.gainX(gainX), .gainY(gainY), .iFe(iFe), .restart(restart),
		.leftX(leftX), .rightX(rightX), .topY(topY), .underY(underY)
	);

	dotSquareGen u_dotGen (
		.iClk(iClk), .arstN(arstN),
		.iHpos(iHpos), .iVpos(iVpos), .color(color),
		.leftX(leftX), .rightX(rightX), .topY(topY), .underY(underY),
		.pixel(pixel)
	);

	// ------------------------------------------------------------------
	// output fifo, aligns with the other dot generators
	// ------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			rWe <= 1'b0;
		else
			rWe <= iEds;   // dot reg adds one cycle
	end

	pixelFifo u_fifo (
		.iClk(iClk), .arstN(arstN),
		.wData(pixel), .we(rWe), .full(oFull),
		.rData(oDd), .rValid(oVdd), .re(iEdd), .empty(oEmp)
	);

	// source holds off on full and never back to back, so rWe never meets full
	srcRule: assert property (@(posedge iClk) disable iff (!arstN)
		iEds |-> !oFull && !rWe)
		else $error("sceneChange: iEds while full or write pending");

endmodule

`default_nettype wire

/* source/sceneChangePkg.sv */
`default_nettype none

package sceneChangePkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int H_POS_W   = 11;            // raster position bits
	localparam int V_POS_W   = 11;
	localparam int H_COORD_W = H_POS_W + 1;   // one extra bit for the sign
	localparam int V_COORD_W = V_POS_W + 1;
	localparam int COLOR_W   = 16;
	localparam int GAIN_W    = 7;
	localparam int ADDR_W    = 3;

	// raster positions straight from upstream, unsigned
	typedef logic [H_POS_W-1:0] hPosT;
	typedef logic [V_POS_W-1:0] vPosT;

	// edges and display size, signed so the centre math can go below zero
	typedef logic signed [H_COORD_W-1:0] hCoordT;
	typedef logic signed [V_COORD_W-1:0] vCoordT;

	typedef logic [COLOR_W-1:0] colorT;   // rgb565 style dot
	typedef logic [GAIN_W-1:0]  gainT;    // half size step per frame
	typedef logic [ADDR_W-1:0]  regAddrT;

	// ------------------------------------------------------------------
	// register map
	// ------------------------------------------------------------------
	localparam regAddrT ADDR_COLOR = 3'd0;
	localparam regAddrT ADDR_HDISP = 3'd1;
	localparam regAddrT ADDR_VDISP = 3'd2;
	localparam regAddrT ADDR_GAINX = 3'd3;
	localparam regAddrT ADDR_GAINY = 3'd4;
	localparam regAddrT ADDR_CTRL  = 3'd5;   // 6 and 7 unused

	localparam int CTRL_RESTART_BIT = 0;     // write 1 here to restart

	// reset values of the config registers
	localparam hCoordT HDISP_RST = 12'sd640;
	localparam vCoordT VDISP_RST = 12'sd480;
	localparam gainT   GAIN_RST  = 7'd8;
	localparam colorT  COLOR_RST = 16'h0000;

	// output fifo
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;           // log2 of depth

endpackage

`default_nettype wire

/* source/sceneChangeRegs.sv */
`default_nettype none

module sceneChangeRegs (
	input  wire logic                    iClk,
	input  wire logic                    arstN,
	// write port
	input  wire logic                    regWe,
	input  wire sceneChangePkg::regAddrT regAddr,
	input  wire sceneChangePkg::colorT   regWdata,
	// config out
	output sceneChangePkg::colorT        color,
	output sceneChangePkg::hCoordT       hDisplay,
	output sceneChangePkg::vCoordT       vDisplay,
	output sceneChangePkg::gainT         gainX,
	output sceneChangePkg::gainT         gainY,
	output logic                         restart
);

	logic ctrlHit;   // write to the control address with restart bit set

	assign ctrlHit = regWe && (regAddr == sceneChangePkg::ADDR_CTRL)
		&& regWdata[sceneChangePkg::CTRL_RESTART_BIT];

	// ------------------------------------------------------------------
	// config registers
	// ------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			color    <= sceneChangePkg::COLOR_RST;
			hDisplay <= sceneChangePkg::HDISP_RST;
			vDisplay <= sceneChangePkg::VDISP_RST;
			gainX    <= sceneChangePkg::GAIN_RST;
			gainY    <= sceneChangePkg::GAIN_RST;
		end
		else if (regWe)
		begin
			case (regAddr)
				sceneChangePkg::ADDR_COLOR: color <= regWdata;
				// sizes use the low bits only
				sceneChangePkg::ADDR_HDISP: hDisplay <= regWdata[sceneChangePkg::H_COORD_W-1:0];
				sceneChangePkg::ADDR_VDISP: vDisplay <= regWdata[sceneChangePkg::V_COORD_W-1:0];
				sceneChangePkg::ADDR_GAINX: gainX <= regWdata[sceneChangePkg::GAIN_W-1:0];
				sceneChangePkg::ADDR_GAINY: gainY <= regWdata[sceneChangePkg::GAIN_W-1:0];
				default: ;   // ctrl handled below, 6/7 dropped
			endcase
		end
	end

	// single cycle restart, high the cycle after the write edge
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			restart <= 1'b0;
		else
			restart <= ctrlHit;
	end

endmodule

`default_nettype wire

/* source/squarePosGen.sv */
`default_nettype none

module squarePosGen (
	input  wire logic                   iClk,
	input  wire logic                   arstN,
	input  wire sceneChangePkg::hCoordT hDisplay,
	input  wire sceneChangePkg::vCoordT vDisplay,
	input  wire sceneChangePkg::gainT   gainX,
	input  wire sceneChangePkg::gainT   gainY,
	input  wire logic                   iFe,        // frame end strobe
	input  wire logic                   restart,
	output sceneChangePkg::hCoordT      leftX,
	output sceneChangePkg::hCoordT      rightX,
	output sceneChangePkg::vCoordT      topY,
	output sceneChangePkg::vCoordT      underY
);

	sceneChangePkg::hCoordT centreX;   // display centre
	sceneChangePkg::vCoordT centreY;
	sceneChangePkg::hCoordT halfW;     // current half width
	sceneChangePkg::vCoordT halfH;
	sceneChangePkg::hCoordT sumW;      // half size after one more step
	sceneChangePkg::vCoordT sumH;
	sceneChangePkg::hCoordT nextW;     // clamped at the centre
	sceneChangePkg::vCoordT nextH;

	assign centreX = hDisplay >>> 1;
	assign centreY = vDisplay >>> 1;

	// gains are unsigned, the cast zero extends
	assign sumW = halfW + sceneChangePkg::hCoordT'(gainX);
	assign sumH = halfH + sceneChangePkg::vCoordT'(gainY);

	assign nextW = (sumW > centreX) ? centreX : sumW;   // saturate
	assign nextH = (sumH > centreY) ? centreY : sumH;

	// ------------------------------------------------------------------
	// half size growth, one step per frame
	// ------------------------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			halfW <= '0;
			halfH <= '0;
		end
		else if (restart)   // beats a frame end in the same cycle
		begin
			halfW <= '0;
			halfH <= '0;
		end
		else if (iFe)
		begin
			halfW <= nextW;
			halfH <= nextH;
		end
	end

	// edges, one cycle behind the half sizes
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			leftX  <= '0;
			rightX <= '0;
			topY   <= '0;
			underY <= '0;
		end
		else
		begin
			leftX  <= centreX - halfW;
			rightX <= centreX + halfW;
			topY   <= centreY - halfH;
			underY <= centreY + halfH;
		end
	end

	// box never inverted, even while the display size is reprogrammed
	edgeOrder: assert property (@(posedge iClk) disable iff (!arstN)
		(leftX <= rightX) && (topY <= underY))
		else $error("squarePosGen: edges crossed left %h right %h", leftX, rightX);

endmodule

`default_nettype wire
